// File: rtl/elev_cfg.svh
// Build-time configuration of the floor-request controller.
// The floor count must fit in a floor code, so keep
// ELEV_FLOOR_COUNT at or below 2**ELEV_FLOOR_WIDTH.

`ifndef ELEV_CFG_SVH
`define ELEV_CFG_SVH

////////////////////////////////////////////////////////////
// Building size
////////////////////////////////////////////////////////////

// Floors served by the car, floor 0 is the lowest
`define ELEV_FLOOR_COUNT 11

// Bits in a floor code
`define ELEV_FLOOR_WIDTH 4

`endif

// File: rtl/elev_pkg.sv
// Types shared by the floor-request controller RTL.
// Sizes come from the configuration header.

`default_nettype none

`include "elev_cfg.svh"

package elev_pkg;

    ////////////////////////////////////////////////////////////
    // Floor codes and masks
    ////////////////////////////////////////////////////////////

    // Floor number, 0 up to ELEV_FLOOR_COUNT - 1
    typedef logic [`ELEV_FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, bit i is floor i
    typedef logic [`ELEV_FLOOR_COUNT-1:0] floor_mask_t;

    ////////////////////////////////////////////////////////////
    // Grouped signals
    ////////////////////////////////////////////////////////////

    // Hall calls and cab panel, used for raw buttons and for lights
    typedef struct packed {
        floor_mask_t hall;
        floor_mask_t cab;
    } button_set_t;

    // Position report from the car's motion controller
    typedef struct packed {
        floor_t floor;
        logic   moving;
    } car_status_t;

endpackage

`default_nettype wire

// File: rtl/request_latch.sv
// Request lights for hall calls and the cab panel.
// Buttons are sampled as levels, so a held button keeps its light set.
// A press for the floor the car reports is dropped, even while moving.
// All lights freeze while halted is high.

`timescale 1ns/1ps
`default_nettype none

`include "elev_cfg.svh"

module request_latch (
    input  logic                 clock,
    input  logic                 reset_n,
    input  elev_pkg::button_set_t buttons,
    input  elev_pkg::car_status_t car,
    input  logic                 halted,
    output elev_pkg::button_set_t lights
);

    import elev_pkg::*;

    floor_mask_t here_mask;
    floor_mask_t hall_press;
    floor_mask_t cab_press;
    button_set_t lights_next;

    ////////////////////////////////////////////////////////////
    // Current floor decode
    ////////////////////////////////////////////////////////////

    // One-hot mask of car.floor, all zero for an out-of-range code
    always_comb begin
        here_mask = '0;
        for (int i = 0; i < `ELEV_FLOOR_COUNT; i++) begin
            here_mask[i] = (car.floor == floor_t'(i));
        end
    end

    // Presses for the floor the car is at never light
    assign hall_press = buttons.hall & ~here_mask;
    assign cab_press  = buttons.cab & ~here_mask;

    ////////////////////////////////////////////////////////////
    // Next light state
    ////////////////////////////////////////////////////////////

    always_comb begin
        lights_next = lights;
        if (!halted) begin
            lights_next.hall = lights.hall | hall_press;
            lights_next.cab  = lights.cab | cab_press;

            // Car standing at a floor serves both its requests
            if (!car.moving) begin
                lights_next.hall = lights_next.hall & ~here_mask;
                lights_next.cab  = lights_next.cab & ~here_mask;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Light registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else begin
            lights <= lights_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/floor_scheduler.sv
// Target floor selection.
// Lowest-numbered lit floor wins, with no regard to travel direction.
// A new target is taken only while the car is stopped at the old one,
// so a request that arrives mid-trip waits for the next stop.

`timescale 1ns/1ps
`default_nettype none

`include "elev_cfg.svh"

module floor_scheduler (
    input  logic                  clock,
    input  logic                  reset_n,
    input  elev_pkg::button_set_t lights,
    input  elev_pkg::car_status_t car,
    output elev_pkg::floor_t      target_floor
);

    import elev_pkg::*;

    floor_mask_t pending;
    floor_t      lowest_floor;
    logic        any_pending;
    logic        at_target;

    ////////////////////////////////////////////////////////////
    // Priority encoder
    ////////////////////////////////////////////////////////////

    // Index of the lowest set bit, 0 when the mask is empty
    function automatic floor_t lowest_set(input floor_mask_t mask);
        floor_t result;
        result = '0;
        // Walk downward so the lowest set bit is written last
        for (int i = `ELEV_FLOOR_COUNT - 1; i >= 0; i--) begin
            if (mask[i]) begin
                result = floor_t'(i);
            end
        end
        return result;
    endfunction

    // Hall and cab requests for a floor are served by the same stop
    assign pending      = lights.hall | lights.cab;
    assign any_pending  = |pending;
    assign lowest_floor = lowest_set(pending);

    ////////////////////////////////////////////////////////////
    // Target register
    ////////////////////////////////////////////////////////////

    assign at_target = !car.moving && (target_floor == car.floor);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= '0;
        end else if (at_target) begin
            if (any_pending) begin
                target_floor <= lowest_floor;
            end else begin
                // Nothing to do, stay where the car is
                target_floor <= car.floor;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/car_command.sv
// Drive command and door permissions for the car.
// run and direction are combinational from target and position.
// Door permissions lag the buttons by one clock.
// The emergency button does not block the doors, only power off does.

`timescale 1ns/1ps
`default_nettype none

module car_command (
    input  logic                  clock,
    input  logic                  reset_n,
    input  elev_pkg::car_status_t car,
    input  elev_pkg::floor_t      target_floor,
    input  logic                  halted,
    input  logic                  power_switch,
    input  logic                  door_open_button,
    input  logic                  door_close_button,
    output logic                  run,
    output logic                  direction,
    output logic                  door_open_allowed,
    output logic                  door_close_allowed
);

    logic direction_q;
    logic door_gate;

    ////////////////////////////////////////////////////////////
    // Run and direction
    ////////////////////////////////////////////////////////////

    // Start a trip only from standstill and only toward a new floor
    assign run = !halted && !car.moving && (target_floor != car.floor);

    // 1 is up; keeps the last trip's direction between trips
    assign direction = run ? (target_floor > car.floor) : direction_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            direction_q <= 1'b0;
        end else begin
            direction_q <= direction;
        end
    end

    ////////////////////////////////////////////////////////////
    // Door permissions
    ////////////////////////////////////////////////////////////

    // Doors may move only with the car stopped and powered
    assign door_gate = !car.moving && power_switch;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_gate & door_open_button;
            door_close_allowed <= door_gate & door_close_button;
        end
    end

endmodule

`default_nettype wire

// File: rtl/floor_logic_top.sv
// Floor-request controller top level.
// Chain is request_latch, then floor_scheduler, then car_command.
// The car position and moving flag come from an external motion
// controller and are trusted as given.

`timescale 1ns/1ps
`default_nettype none

module floor_logic_top (
    input  logic                  clock,
    input  logic                  reset_n,
    input  elev_pkg::button_set_t buttons,
    input  elev_pkg::car_status_t car,
    input  logic                  door_open_button,
    input  logic                  door_close_button,
    input  logic                  emergency_button,
    input  logic                  power_switch,
    output elev_pkg::button_set_t lights,
    output elev_pkg::floor_t      target_floor,
    output logic                  run,
    output logic                  direction,
    output logic                  door_open_allowed,
    output logic                  door_close_allowed
);

    logic halted;

    // Power loss or emergency stop freezes requests and motion
    assign halted = !power_switch || emergency_button;

    ////////////////////////////////////////////////////////////
    // Request chain
    ////////////////////////////////////////////////////////////

    request_latch u_request_latch (
        .clock   (clock),
        .reset_n (reset_n),
        .buttons (buttons),
        .car     (car),
        .halted  (halted),
        .lights  (lights)
    );

    floor_scheduler u_floor_scheduler (
        .clock        (clock),
        .reset_n      (reset_n),
        .lights       (lights),
        .car          (car),
        .target_floor (target_floor)
    );

    car_command u_car_command (
        .clock              (clock),
        .reset_n            (reset_n),
        .car                (car),
        .target_floor       (target_floor),
        .halted             (halted),
        .power_switch       (power_switch),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .run                (run),
        .direction          (direction),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

// File: testbench/floor_logic_sva.sv
// Concurrent checks on the top-level drive and door outputs.
// Bound into floor_logic_top, all checks are off while reset_n is low.

`timescale 1ns/1ps
`default_nettype none

module floor_logic_sva (
    input logic                  clock,
    input logic                  reset_n,
    input elev_pkg::car_status_t car,
    input elev_pkg::floor_t      target_floor,
    input logic                  power_switch,
    input logic                  emergency_button,
    input logic                  door_open_button,
    input logic                  door_close_button,
    input logic                  run,
    input logic                  direction,
    input logic                  door_open_allowed,
    input logic                  door_close_allowed
);

    ////////////////////////////////////////////////////////////
    // Drive command
    ////////////////////////////////////////////////////////////

    run_only_stopped: assert property (@(posedge clock) disable iff (!reset_n)
        car.moving |-> !run)
        else $error("run is high while the car is moving");

    run_rule: assert property (@(posedge clock) disable iff (!reset_n)
        run == (power_switch && !emergency_button && !car.moving
                && (target_floor != car.floor)))
        else $error("run does not match target, floor and halt state");

    direction_toward_target: assert property (@(posedge clock) disable iff (!reset_n)
        run |-> (direction == (target_floor > car.floor)))
        else $error("direction does not point at the target");

    // Between trips the last direction is kept
    direction_hold: assert property (@(posedge clock) disable iff (!reset_n)
        !run |-> (direction == $past(direction)))
        else $error("direction changed while run is low");

    ////////////////////////////////////////////////////////////
    // Door permissions
    ////////////////////////////////////////////////////////////

    door_open_rule: assert property (@(posedge clock) disable iff (!reset_n)
        door_open_allowed == $past(door_open_button && !car.moving && power_switch))
        else $error("door_open_allowed does not follow the gated button");

    door_close_rule: assert property (@(posedge clock) disable iff (!reset_n)
        door_close_allowed == $past(door_close_button && !car.moving && power_switch))
        else $error("door_close_allowed does not follow the gated button");

endmodule

bind floor_logic_top floor_logic_sva u_floor_logic_sva (
    .clock              (clock),
    .reset_n            (reset_n),
    .car                (car),
    .target_floor       (target_floor),
    .power_switch       (power_switch),
    .emergency_button   (emergency_button),
    .door_open_button   (door_open_button),
    .door_close_button  (door_close_button),
    .run                (run),
    .direction          (direction),
    .door_open_allowed  (door_open_allowed),
    .door_close_allowed (door_close_allowed)
);

`default_nettype wire

// File: testbench/floor_logic_tb.sv
// Testbench for floor_logic_top. The testbench plays the car's motion controller.
// It starts a trip when it sees run, and steps one floor per STEP_CYCLES + 1 clocks.
// A reference model of the lights, target, direction hold and door flags
// is checked against every output just after each rising edge.

`timescale 1ns/1ps
`default_nettype none

`include "elev_cfg.svh"

module floor_logic_tb;

    import elev_pkg::*;

    localparam int CLOCK_PERIOD  = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int STEP_CYCLES   = 3;
    localparam int FIXED_CYCLES  = 100;
    localparam int RANDOM_CYCLES = 600;
    localparam int IDLE_LIMIT    = 400;
    localparam int IDLE_WAITS    = 5;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + FIXED_CYCLES + RANDOM_CYCLES
                                   + IDLE_WAITS * IDLE_LIMIT;
    localparam int MARGIN_NS     = 2000;
    localparam logic [31:0] SEED = 32'h433755bc;

    // Model state, all zero out of reset
    typedef struct packed {
        button_set_t lights;
        floor_t      target;
        logic        dir_q;
        logic        door_open;
        logic        door_close;
    } model_t;

    logic        clock = 1'b0;
    logic        reset_n;
    button_set_t buttons;
    car_status_t car;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency_button;
    logic        power_switch;
    button_set_t lights;
    floor_t      target_floor;
    logic        run;
    logic        direction;
    logic        door_open_allowed;
    logic        door_close_allowed;

    model_t      model = '0;
    string       test_name = "reset";
    logic        start_seen;
    floor_t      dest;
    int          hold;

    floor_logic_top DUT (
        .clock              (clock),
        .reset_n            (reset_n),
        .buttons            (buttons),
        .car                (car),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .emergency_button   (emergency_button),
        .power_switch       (power_switch),
        .lights             (lights),
        .target_floor       (target_floor),
        .run                (run),
        .direction          (direction),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic expect_run(input floor_t target, input car_status_t c,
                                        input logic pwr, input logic emerg);
        return pwr && !emerg && !c.moving && (target != c.floor);
    endfunction

    function automatic logic expect_direction(input floor_t target, input car_status_t c,
                                              input logic pwr, input logic emerg,
                                              input logic dir_q);
        if (expect_run(target, c, pwr, emerg)) begin
            return target > c.floor;
        end
        return dir_q;
    endfunction

    // State after one rising edge, from the state and inputs before it
    function automatic model_t ref_next(input model_t s, input button_set_t b,
                                        input car_status_t c, input logic pwr,
                                        input logic emerg, input logic d_open,
                                        input logic d_close);
        model_t n;
        logic   found;
        n = s;
        if (pwr && !emerg) begin
            for (int f = 0; f < `ELEV_FLOOR_COUNT; f++) begin
                if (floor_t'(f) != c.floor) begin
                    n.lights.hall[f] = s.lights.hall[f] | b.hall[f];
                    n.lights.cab[f]  = s.lights.cab[f] | b.cab[f];
                end else if (!c.moving) begin
                    n.lights.hall[f] = 1'b0;
                    n.lights.cab[f]  = 1'b0;
                end
            end
        end
        // New target only when stopped at the old one
        if (!c.moving && (s.target == c.floor)) begin
            n.target = c.floor;
            found = 1'b0;
            for (int f = 0; f < `ELEV_FLOOR_COUNT; f++) begin
                if (!found && (s.lights.hall[f] || s.lights.cab[f])) begin
                    n.target = floor_t'(f);
                    found = 1'b1;
                end
            end
        end
        n.dir_q      = expect_direction(s.target, c, pwr, emerg, s.dir_q);
        n.door_open  = d_open && !c.moving && pwr;
        n.door_close = d_close && !c.moving && pwr;
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic compare_outputs();
        logic exp_run;
        logic exp_dir;
        exp_run = expect_run(model.target, car, power_switch, emergency_button);
        exp_dir = expect_direction(model.target, car, power_switch, emergency_button,
                                   model.dir_q);
        check_value("lights", 32'(model.lights), 32'(lights));
        check_value("target_floor", 32'(model.target), 32'(target_floor));
        check_value("run", 32'(exp_run), 32'(run));
        check_value("direction", 32'(exp_dir), 32'(direction));
        check_value("door_open_allowed", 32'(model.door_open), 32'(door_open_allowed));
        check_value("door_close_allowed", 32'(model.door_close), 32'(door_close_allowed));
    endtask

    // Step the model on the edge, then look once the DUT has settled
    always @(posedge clock) begin
        if (!reset_n) begin
            model = '0;
        end else begin
            model = ref_next(model, buttons, car, power_switch, emergency_button,
                             door_open_button, door_close_button);
        end
        #1;
        compare_outputs();
    end

    ////////////////////////////////////////////////////////////
    // Car model
    ////////////////////////////////////////////////////////////

    // Pre-edge run, so the car never races the stimulus
    always @(posedge clock) begin
        start_seen <= run;
    end

    initial begin : car_model
        car.floor  = '0;
        car.moving = 1'b0;
        dest = '0;
        hold = 0;
        forever begin
            @(negedge clock);
            if (!reset_n) begin
                car.moving = 1'b0;
            end else if (car.moving) begin
                if (hold > 0) begin
                    hold--;
                end else begin
                    car.floor = (dest > car.floor) ? car.floor + floor_t'(1)
                                                   : car.floor - floor_t'(1);
                    hold = STEP_CYCLES;
                    if (car.floor == dest) begin
                        car.moving = 1'b0;
                    end
                end
            end else if (start_seen) begin
                dest = target_floor;
                car.moving = 1'b1;
                hold = STEP_CYCLES;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic press_for_cycle(input floor_mask_t hall, input floor_mask_t cab);
        @(negedge clock);
        buttons.hall = hall;
        buttons.cab  = cab;
        @(negedge clock);
        buttons = '0;
    endtask

    // Returns once the car has left standstill
    task automatic wait_moving();
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clock);
            if (car.moving) begin
                break;
            end
            cycles++;
            if (cycles >= IDLE_LIMIT) begin
                $display("Car did not start a trip in test %s", test_name);
                $display("Simulation failed");
                $fatal(1, "Start wait timed out");
            end
        end
    endtask

    // Idle means stopped at the target with nothing lit
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clock);
            if (!car.moving && !run && (lights == '0) && (target_floor == car.floor)) begin
                break;
            end
            cycles++;
            if (cycles >= IDLE_LIMIT) begin
                $display("Car did not come to rest in test %s", test_name);
                $display("Simulation failed");
                $fatal(1, "Idle wait timed out");
            end
        end
    endtask

    initial begin : stimulus
        void'($urandom(SEED));
        reset_n           = 1'b0;
        buttons           = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency_button  = 1'b0;
        power_switch      = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        test_name = "press_here_ignored";
        press_for_cycle(floor_mask_t'(1), floor_mask_t'(1));
        repeat (2) @(negedge clock);

        test_name = "single_trip";
        press_for_cycle('0, floor_mask_t'(1) << 5);
        wait_moving();

        // Car has just left floor 0 and still reports it, no stop there to clear
        test_name = "press_here_moving";
        press_for_cycle(floor_mask_t'(1), floor_mask_t'(1));
        wait_idle();

        // Car is at floor 5, so the hall press there must not light
        test_name = "lowest_first";
        press_for_cycle((floor_mask_t'(1) << 8) | (floor_mask_t'(1) << 5),
                        floor_mask_t'(1) << 2);
        wait_idle();

        test_name = "power_off";
        @(negedge clock);
        power_switch = 1'b0;
        door_open_button = 1'b1;
        press_for_cycle(floor_mask_t'(1) << 9, '0);
        repeat (2) @(negedge clock);
        power_switch = 1'b1;
        door_open_button = 1'b0;

        test_name = "emergency";
        press_for_cycle('0, floor_mask_t'(1) << 1);
        emergency_button = 1'b1;
        door_close_button = 1'b1;
        repeat (10) @(negedge clock);
        emergency_button = 1'b0;
        door_close_button = 1'b0;
        wait_idle();

        test_name = "random";
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            @(negedge clock);
            buttons = '0;
            if ($urandom_range(0, 3) == 0) begin
                buttons.hall = floor_mask_t'(1) << $urandom_range(0, `ELEV_FLOOR_COUNT - 1);
            end
            if ($urandom_range(0, 3) == 0) begin
                buttons.cab = floor_mask_t'(1) << $urandom_range(0, `ELEV_FLOOR_COUNT - 1);
            end
            power_switch      = ($urandom_range(0, 19) != 0);
            emergency_button  = ($urandom_range(0, 24) == 0);
            door_open_button  = 1'($urandom);
            door_close_button = 1'($urandom);
        end
        @(negedge clock);
        buttons = '0;
        power_switch = 1'b1;
        emergency_button = 1'b0;
        door_open_button = 1'b0;
        door_close_button = 1'b0;
        wait_idle();

        @(negedge clock);
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin : watchdog
        #(TOTAL_CYCLES * CLOCK_PERIOD + MARGIN_NS);
        $display("Timeout: the run did not end within %0d cycles", TOTAL_CYCLES);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/elev_pkg.sv
rtl/request_latch.sv
rtl/floor_scheduler.sv
rtl/car_command.sv
rtl/floor_logic_top.sv
testbench/floor_logic_sva.sv
testbench/floor_logic_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the floor-request controller testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module floor_logic_tb \
    -f sources.f \
    -Mdir obj_dir

# The simulator status is not trusted alone, the log decides
./obj_dir/Vfloor_logic_tb 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: testbench reported failure"
    exit 1
fi

if ! grep -q "Simulation completed successfully" sim.log; then
    echo "run.sh: no pass line found in sim.log"
    exit 1
fi

echo "run.sh: done"
